// File: storeMemSystem_golden.txt
// Columns: op a b c d, hex. 1 token: mask cnt0 cnt1 0 | 2 store: port addr data 0
// 3 pair: addr0 data0 addr1 data1 | 4 addr-first: port addr data hold | 5 read: addr expected
// 6 wait done | 0 end of commands

// Zero token on channel 1 keeps done low for its cycle
1 2 0 0 0
6 0 0 0 0

// Single store on port 1
1 1 1 0 0
2 1 0a 1234abcd 0
6 0 0 0 0
5 0a 1234abcd 0 0

// Both ports complete on one address, port 1 lands last
1 1 2 0 0
3 14 aaaa0000 14 bbbb1111
6 0 0 0 0
5 14 bbbb1111 0 0

// Both ports complete on different addresses
1 2 0 2 0
3 15 11111111 16 22222222
6 0 0 0 0
5 15 11111111 0 0
5 16 22222222 0 0

// Port 1 offers its address four cycles before its data
1 1 1 0 0
4 1 1e 0c0ffee0 4
6 0 0 0 0
5 1e 0c0ffee0 0 0

// Port 0 offers its address three cycles before its data
1 2 0 1 0
4 0 1f 3c3c5a5a 3
6 0 0 0 0
5 1f 3c3c5a5a 0 0

// Tokens of 2 and 3 in one cycle, five stores before done
1 3 2 3 0
3 28 40404040 29 41414141
2 1 2a 42424242 0
4 0 2b 43434343 2
2 0 2c 44444444 0
6 0 0 0 0
5 28 40404040 0 0
5 29 41414141 0 0
5 2a 42424242 0 0
5 2b 43434343 0 0
5 2c 44444444 0 0

// Overwrite an earlier address
1 1 1 0 0
2 0 0a 5a5a5a5a 0
6 0 0 0 0
5 0a 5a5a5a5a 0 0

// Zero tokens on both channels at once
1 3 0 0 0
6 0 0 0 0

// First and last word of the RAM
1 3 1 1 0
2 1 ff 87654321 0
2 0 00 0f0f0f0f 0
6 0 0 0 0
5 ff 87654321 0 0
5 00 0f0f0f0f 0 0

// Earlier words still hold their data
5 14 bbbb1111 0 0
5 1e 0c0ffee0 0 0
0 0 0 0 0

// File: project.f
memCtrlPkg.sv
storeArbiter.sv
memControllerLoadless.sv
blockRam.sv
storeMemSystem.sv
storeMemSystem_assertions.sv
storeMemSystem_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = storeMemSystem_tb
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
	  echo "Failure found in $(LOG)"; \
	  exit 1; \
	fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: storeMemSystem_tb.sv
`timescale 1ns/10ps

module storeMemSystem_tb;
  import memCtrlPkg::*;

  // Five hex words per golden command
  localparam int WordsPerCmd = 5;
  localparam int MaxCmds = 80;
  // About 50 commands of at most 22 cycles each, plus reset
  localparam int CycleLimit = 2000;
  localparam int DoneTimeout = 20;
  localparam int DoneLatency = 2;

  logic                                   clk;
  logic                                   rst;
  storeReq_t [NumStores-1:0]              stReq;
  logic [NumStores-1:0]                   stAddrValid;
  logic [NumStores-1:0]                   stDataValid;
  logic [NumStores-1:0]                   stReady;
  logic [NumControls-1:0][CountWidth-1:0] ctrl;
  logic [NumControls-1:0]                 ctrlValid;
  logic [NumControls-1:0]                 ctrlReady;
  logic                                   memDoneValid;
  logic                                   memDoneReady;
  hostRead_t                              hostRead;
  logic [DataWidth-1:0]                   readData;

  logic [31:0]           golden [WordsPerCmd*MaxCmds];
  logic [DataWidth-1:0]  model [int];
  logic [CountWidth-1:0] modelCount;
  logic                  modelWrite;
  int                    cycleCount;
  int                    lastAccept;
  bit                    storeSinceDone;
  string                 testName;

  storeMemSystem i_dut (
    .clk          (clk),
    .rst          (rst),
    .stReq        (stReq),
    .stAddrValid  (stAddrValid),
    .stDataValid  (stDataValid),
    .stReady      (stReady),
    .ctrl         (ctrl),
    .ctrlValid    (ctrlValid),
    .ctrlReady    (ctrlReady),
    .memDoneValid (memDoneValid),
    .memDoneReady (memDoneReady),
    .hostRead     (hostRead),
    .readData     (readData)
  );

  always #4 clk = ~clk;

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      abortRun($sformatf("Fail %s %s: expected %h, actual %h",
                         testName, name, expected, actual));
    end
  endtask

  // Lowest complete port wins the grant
  function automatic logic [NumStores-1:0] lowestSet(input logic [NumStores-1:0] mask);
    return mask & (~mask + 1'b1);
  endfunction

  // Run length guard
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      abortRun($sformatf("Timeout after %0d cycles, the run did not finish", cycleCount));
    end
  end

  // Reference count of outstanding stores
  always @(posedge clk or posedge rst) begin
    logic [CountWidth-1:0] tokens;
    if (rst) begin
      modelCount = '0;
      modelWrite = 1'b0;
    end else begin
      tokens = '0;
      for (int i = 0; i < NumControls; i++) begin
        if (ctrlValid[i]) begin
          tokens = tokens + ctrl[i];
        end
      end
      modelCount = modelCount + tokens - CountWidth'(modelWrite);
      modelWrite = |(stAddrValid & stDataValid);
    end
  end

  // Grant, done and control ready checked at every falling edge
  always @(negedge clk) begin
    if (!rst) begin
      check("grant", 32'(lowestSet(stAddrValid & stDataValid)), 32'(stReady));
      check("done level", 32'((modelCount == '0) && (ctrlValid == '0)), 32'(memDoneValid));
      check("ctrl ready", 32'({NumControls{1'b1}}), 32'(ctrlReady));
    end
  end

  task automatic offerStore(input int port, input logic [31:0] addr,
                            input logic [31:0] data, input bit addrOnly);
    stReq[port].addr = addr[AddrWidth-1:0];
    stReq[port].data = data;
    stAddrValid[port] = 1'b1;
    stDataValid[port] = !addrOnly;
  endtask

  // Wait for the grant, then retire the store into the model
  task automatic awaitAccept(input int port);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!stReady[port]) begin
      waited++;
      if (waited > DoneTimeout) begin
        abortRun($sformatf("Store on port %0d was never accepted", port));
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    lastAccept = cycleCount;
    storeSinceDone = 1'b1;
    model[int'(stReq[port].addr)] = stReq[port].data;
    stAddrValid[port] = 1'b0;
    stDataValid[port] = 1'b0;
  endtask

  task automatic storeAddrFirst(input int port, input logic [31:0] addr,
                                input logic [31:0] data, input int hold);
    offerStore(port, addr, data, 1'b1);
    repeat (hold) begin
      @(negedge clk);
      check("ready while data missing", 32'h0, 32'(stReady[port]));
      @(posedge clk);
      #1;
    end
    stDataValid[port] = 1'b1;
    awaitAccept(port);
  endtask

  task automatic storePair(input logic [31:0] addr0, input logic [31:0] data0,
                           input logic [31:0] addr1, input logic [31:0] data1);
    offerStore(0, addr0, data0, 1'b0);
    offerStore(1, addr1, data1, 1'b0);
    // Fixed priority, so grants come in index order
    for (int p = 0; p < NumStores; p++) begin
      awaitAccept(p);
    end
  endtask

  task automatic sendToken(input logic [31:0] mask, input logic [31:0] count0,
                           input logic [31:0] count1);
    ctrlValid = mask[NumControls-1:0];
    ctrl[0] = count0;
    ctrl[1] = count1;
    @(negedge clk);
    check("done with token", 32'h0, 32'(memDoneValid));
    @(posedge clk);
    #1;
    ctrlValid = '0;
  endtask

  task automatic readBack(input logic [31:0] addr, input logic [31:0] expected);
    if (!model.exists(int'(addr[AddrWidth-1:0]))) begin
      abortRun($sformatf("Golden read of address %h that no store wrote", addr));
    end
    check("write order", expected, model[int'(addr[AddrWidth-1:0])]);
    hostRead.en = 1'b1;
    hostRead.addr = addr[AddrWidth-1:0];
    @(posedge clk);
    #1;
    hostRead.en = 1'b0;
    check("readback", expected, readData);
  endtask

  task automatic waitDone();
    int waited;
    int latency;
    waited = 0;
    @(negedge clk);
    while (!memDoneValid) begin
      waited++;
      if (waited >= DoneTimeout) begin
        abortRun($sformatf("Memory done never rose within %0d cycles", DoneTimeout));
      end
      @(negedge clk);
    end
    latency = cycleCount - lastAccept;
    if (storeSinceDone && latency > DoneLatency) begin
      abortRun($sformatf("Memory done rose %0d cycles after the last store", latency));
    end
    storeSinceDone = 1'b0;
    @(posedge clk);
    #1;
  endtask

  initial begin
    int base;
    logic [31:0] op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    clk = 1'b0;
    rst = 1'b1;
    stReq = '0;
    stAddrValid = '0;
    stDataValid = '0;
    ctrl = '0;
    ctrlValid = '0;
    memDoneReady = 1'b1;
    hostRead = '0;
    cycleCount = 0;
    lastAccept = 0;
    storeSinceDone = 1'b0;
    testName = "reset";
    $readmemh("storeMemSystem_golden.txt", golden);

    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check("done after reset", 32'h1, 32'(memDoneValid));
    check("readData after reset", 32'h0, readData);
    @(posedge clk);
    #1;

    for (int idx = 0; idx < MaxCmds; idx++) begin
      base = idx * WordsPerCmd;
      op = golden[base];
      a = golden[base+1];
      b = golden[base+2];
      c = golden[base+3];
      d = golden[base+4];
      if (op == 32'h0) begin
        break;
      end
      case (op)
        32'h1: begin
          testName = $sformatf("cmd %0d token", idx);
          sendToken(a, b, c);
        end
        32'h2: begin
          testName = $sformatf("cmd %0d store", idx);
          offerStore(int'(a), b, c, 1'b0);
          awaitAccept(int'(a));
        end
        32'h3: begin
          testName = $sformatf("cmd %0d pair store", idx);
          storePair(a, b, c, d);
        end
        32'h4: begin
          testName = $sformatf("cmd %0d addr-first store", idx);
          storeAddrFirst(int'(a), b, c, int'(d));
        end
        32'h5: begin
          testName = $sformatf("cmd %0d read", idx);
          readBack(a, b);
        end
        32'h6: begin
          testName = $sformatf("cmd %0d wait done", idx);
          waitDone();
        end
        default: begin
          abortRun($sformatf("Unknown golden command %h at entry %0d", op, idx));
        end
      endcase
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: storeMemSystem_assertions.sv
`timescale 1ns/10ps

module storeMemAssertions (
  input logic                             clk,
  input logic                             rst,
  input logic [memCtrlPkg::NumStores-1:0] stReady,
  input logic [memCtrlPkg::NumStores-1:0] stAddrValid,
  input logic [memCtrlPkg::NumStores-1:0] stDataValid,
  input logic                             writeEn,
  input logic                             loadEn
);

  // At most one port granted per cycle
  assert property (@(posedge clk) disable iff (rst) $onehot0(stReady))
    else $error("stReady has more than one bit set");

  // Grant only toward a port with both channels valid
  assert property (@(posedge clk) disable iff (rst)
    (stReady & ~(stAddrValid & stDataValid)) == '0)
    else $error("stReady given to a port that is not complete");

  // Accepted store shows up as a RAM write one cycle later
  assert property (@(posedge clk) disable iff (rst)
    |(stReady & stAddrValid & stDataValid) |=> writeEn)
    else $error("No memWrite enable after an accepted store");

  // Store-only controller
  assert property (@(posedge clk) disable iff (rst) !loadEn)
    else $error("loadEn went high");

endmodule

// Arbiter side, handshake and write timing
bind storeArbiter storeMemAssertions i_arbiterChecks (
  .clk         (clk),
  .rst         (rst),
  .stReady     (stReady),
  .stAddrValid (stAddrValid),
  .stDataValid (stDataValid),
  .writeEn     (memWrite.en),
  .loadEn      (1'b0)
);

// Controller has no store handshake, only its load port is watched
bind memControllerLoadless storeMemAssertions i_controllerChecks (
  .clk         (clk),
  .rst         (rst),
  .stReady     ('0),
  .stAddrValid ('0),
  .stDataValid ('0),
  .writeEn     (1'b0),
  .loadEn      (loadEn)
);

// File: storeMemSystem.sv
`timescale 1ns/10ps

module storeMemSystem (
  input  logic                                                             clk,
  input  logic                                                             rst,
  input  memCtrlPkg::storeReq_t [memCtrlPkg::NumStores-1:0]               stReq,
  input  logic [memCtrlPkg::NumStores-1:0]                               stAddrValid,
  input  logic [memCtrlPkg::NumStores-1:0]                               stDataValid,
  output logic [memCtrlPkg::NumStores-1:0]                               stReady,
  input  logic [memCtrlPkg::NumControls-1:0][memCtrlPkg::CountWidth-1:0] ctrl,
  input  logic [memCtrlPkg::NumControls-1:0]                             ctrlValid,
  output logic [memCtrlPkg::NumControls-1:0]                             ctrlReady,
  output logic                                                           memDoneValid,
  input  logic                                                           memDoneReady,
  input  memCtrlPkg::hostRead_t                                          hostRead,
  output logic [memCtrlPkg::DataWidth-1:0]                               readData
);
  import memCtrlPkg::*;

  // Registered store from the arbiter, shared by RAM and controller
  memWrite_t memWrite;

  // Picks one complete store port per cycle
  storeArbiter i_storeArbiter (
    .clk         (clk),
    .rst         (rst),
    .stReq       (stReq),
    .stAddrValid (stAddrValid),
    .stDataValid (stDataValid),
    .stReady     (stReady),
    .memWrite    (memWrite)
  );

  // Tracks outstanding stores and signals completion
  memControllerLoadless i_memController (
    .clk          (clk),
    .rst          (rst),
    .ctrl         (ctrl),
    .ctrlValid    (ctrlValid),
    .ctrlReady    (ctrlReady),
    .memWrite     (memWrite),
    .memDoneValid (memDoneValid),
    .memDoneReady (memDoneReady),
    .loadEn       (),
    .loadAddr     ()
  );

  // Store data on port A, host readback on port B
  blockRam i_blockRam (
    .clk      (clk),
    .rst      (rst),
    .memWrite (memWrite),
    .hostRead (hostRead),
    .readData (readData)
  );

endmodule

// File: blockRam.sv
`timescale 1ns/10ps

module blockRam (
  input  logic                            clk,
  input  logic                            rst,
  input  memCtrlPkg::memWrite_t           memWrite,
  input  memCtrlPkg::hostRead_t           hostRead,
  output logic [memCtrlPkg::DataWidth-1:0] readData
);
  import memCtrlPkg::*;

  logic [DataWidth-1:0] mem [RamDepth];

  // Port A, store writes from the arbiter
  always_ff @(posedge clk) begin
    if (memWrite.en) begin
      mem[memWrite.addr] <= memWrite.data;
    end
  end

  // Port B, host readback with registered output
  // Same-edge write to the same address returns the old word
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      readData <= '0;
    end else if (hostRead.en) begin
      readData <= mem[hostRead.addr];
    end
  end

endmodule

// File: memControllerLoadless.sv
`timescale 1ns/10ps

module memControllerLoadless (
  input  logic                                                             clk,
  input  logic                                                             rst,
  input  logic [memCtrlPkg::NumControls-1:0][memCtrlPkg::CountWidth-1:0] ctrl,
  input  logic [memCtrlPkg::NumControls-1:0]                             ctrlValid,
  output logic [memCtrlPkg::NumControls-1:0]                             ctrlReady,
  input  memCtrlPkg::memWrite_t                                          memWrite,
  output logic                                                           memDoneValid,
  input  logic                                                           memDoneReady,
  output logic                                                           loadEn,
  output logic [memCtrlPkg::AddrWidth-1:0]                               loadAddr
);
  import memCtrlPkg::*;

  // Stores announced by control tokens but not yet written
  logic [CountWidth-1:0] count;
  logic [CountWidth-1:0] countNext;

  // Sum of all tokens arriving this cycle
  logic [CountWidth-1:0] tokenSum;

  // Tokens are always taken
  assign ctrlReady = '1;

  always_comb begin
    tokenSum = '0;
    for (int i = 0; i < NumControls; i++) begin
      if (ctrlValid[i]) begin
        tokenSum = tokenSum + ctrl[i];
      end
    end
  end

  // Add new tokens and retire one store per RAM write
  assign countNext = count + tokenSum - {{(CountWidth-1){1'b0}}, memWrite.en};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
    end else begin
      count <= countNext;
    end
  end

  // Done is a plain level; memDoneReady never holds it back
  assign memDoneValid = (count == '0) && (ctrlValid == '0);

  // Store-only controller, load port stays idle
  assign loadEn   = 1'b0;
  assign loadAddr = '0;

endmodule

// File: storeArbiter.sv
`timescale 1ns/10ps

module storeArbiter (
  input  logic                                             clk,
  input  logic                                             rst,
  input  memCtrlPkg::storeReq_t [memCtrlPkg::NumStores-1:0] stReq,
  input  logic [memCtrlPkg::NumStores-1:0]                 stAddrValid,
  input  logic [memCtrlPkg::NumStores-1:0]                 stDataValid,
  output logic [memCtrlPkg::NumStores-1:0]                 stReady,
  output memCtrlPkg::memWrite_t                            memWrite
);
  import memCtrlPkg::*;

  // A port is complete when address and data are both offered
  logic [NumStores-1:0] complete;
  logic [NumStores-1:0] grant;

  // Request chosen this cycle
  storeReq_t selReq;

  // Request being written next cycle
  storeReq_t pendReq;
  logic      pendEn;

  assign complete = stAddrValid & stDataValid;

  // Fixed priority, lowest index first
  always_comb begin
    logic found;
    found = 1'b0;
    grant = '0;
    for (int i = 0; i < NumStores; i++) begin
      if (complete[i] && !found) begin
        grant[i] = 1'b1;
        found = 1'b1;
      end
    end
  end

  // Pick the granted port's payload
  always_comb begin
    selReq = '0;
    for (int i = 0; i < NumStores; i++) begin
      if (grant[i]) begin
        selReq = stReq[i];
      end
    end
  end

  // Address and data channels of a port handshake together
  assign stReady = grant;

  // Write enable for the accepted store, one cycle later
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pendEn <= 1'b0;
    end else begin
      pendEn <= |grant;
    end
  end

  // Payload only matters while pendEn is high
  always_ff @(posedge clk) begin
    if (|grant) begin
      pendReq <= selReq;
    end
  end

  assign memWrite = '{en: pendEn, addr: pendReq.addr, data: pendReq.data};

endmodule

// File: memCtrlPkg.sv
package memCtrlPkg;

  // Port counts
  localparam int NumStores = 2;
  localparam int NumControls = 2;

  // Datapath widths
  localparam int DataWidth = 32;
  localparam int AddrWidth = 8;

  // Control token and outstanding-store counter width
  localparam int CountWidth = 32;

  // One RAM word per address
  localparam int RamDepth = 1 << AddrWidth;

  // One store port's address and data
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] data;
  } storeReq_t;

  // Arbiter write request into the RAM and the controller
  typedef struct packed {
    logic                 en;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] data;
  } memWrite_t;

  // Host readback request on the second RAM port
  typedef struct packed {
    logic                 en;
    logic [AddrWidth-1:0] addr;
  } hostRead_t;

endpackage
